// ==== rtl/idmaPkg.sv ====
package idmaPkg;

  // memory word address width, page bits included.
  localparam int memAddrW = 12;

  // host port pins as sampled on DSPCLK.
  typedef struct packed {
    logic        selN;
    logic        latch;
    logic        rdN;
    logic        wrN;
    logic [15:0] data;
  } hostBusT;

  // control register, loaded by a latch cycle with data bit 15 low.
  typedef struct packed {
    logic        dmFlag;
    logic [13:0] addr;
  } idmaCtlT;

  // overlay register, loaded by a latch cycle with data bit 15 high.
  typedef struct packed {
    logic [3:0] pmPage;
    logic [3:0] dmPage;
  } idmaOvlT;

  // one access toward the memories.
  typedef struct packed {
    logic                dmEn;
    logic                pmEn;
    logic                writeEn;
    logic [memAddrW-1:0] address;
    logic [23:0]         wdata;
  } memReqT;

  typedef enum logic [2:0] {
    idle,
    waitCount,
    request,
    readReturn,
    finish
  } cycleStateE;

endpackage

// ==== rtl/hostSync.sv ====
`timescale 1ns/100ps

module hostSync (
  input  logic             DSPCLK,
  input  logic             RST,
  input  idmaPkg::hostBusT hostIn,
  output idmaPkg::hostBusT hostReg,
  output logic             rdCmd,
  output logic             wrCmd,
  output logic             rdBeg,
  output logic             wrBeg,
  output logic             rdEnd
);

  logic        selN;
  logic        latch;
  logic        rdN;
  logic        wrN;
  logic [15:0] dataQ;
  logic        rdCmdD;
  logic        wrCmdD;

  // strobes and command levels, idle is all strobes high.
  always_ff @(posedge DSPCLK or posedge RST) begin
    if (RST) begin
      selN   <= 1'b1;
      latch  <= 1'b0;
      rdN    <= 1'b1;
      wrN    <= 1'b1;
      rdCmd  <= 1'b0;
      wrCmd  <= 1'b0;
      rdCmdD <= 1'b0;
      wrCmdD <= 1'b0;
    end else begin
      selN   <= hostIn.selN;
      latch  <= hostIn.latch;
      rdN    <= hostIn.rdN;
      wrN    <= hostIn.wrN;
      rdCmd  <= !(hostIn.selN || hostIn.rdN);
      wrCmd  <= !(hostIn.selN || hostIn.wrN);
      rdCmdD <= rdCmd;
      wrCmdD <= wrCmd;
    end
  end

  // bus word is only taken while the port is selected.
  always_ff @(posedge DSPCLK) begin
    if (!hostIn.selN) begin
      dataQ <= hostIn.data;
    end
  end

  always_comb begin
    hostReg.selN  = selN;
    hostReg.latch = latch;
    hostReg.rdN   = rdN;
    hostReg.wrN   = wrN;
    hostReg.data  = dataQ;
  end

  assign rdBeg = rdCmd && !rdCmdD;
  assign wrBeg = wrCmd && !wrCmdD;
  // read strobe released.
  assign rdEnd = !rdCmd && rdCmdD;

endmodule

// ==== rtl/idmaPort.sv ====
`timescale 1ns/100ps

module idmaPort #(
  parameter int addrBits = 10
) (
  input  logic             DSPCLK,
  input  logic             RST,
  input  idmaPkg::hostBusT hostReg,
  input  logic             rdCmd,
  input  logic             wrCmd,
  input  logic             rdBeg,
  input  logic             wrBeg,
  input  logic             rdEnd,
  input  logic [2:0]       writeWait,
  input  logic [2:0]       readWait,
  input  logic             dsAck,
  input  logic [15:0]      dmRdata,
  input  logic [23:0]      pmRdata,
  output logic             dsReq,
  output idmaPkg::memReqT  memReq,
  output logic [15:0]      hostData,
  output logic             hostDataOe,
  output logic             hostAckN
);

  import idmaPkg::*;

  idmaCtlT     ctl;
  idmaOvlT     ovl;
  cycleStateE  state;
  logic        cycRead;
  logic        pmFirst;
  logic [2:0]  wrCnt;
  logic [2:0]  rdCnt;
  logic [15:0] dataHi;
  logic [7:0]  dataLo;
  logic        ldCtl;
  logic        ldOvl;
  logic        pmSecond;
  logic        wrAccess;
  logic        wrZero;
  logic        rdZero;
  logic        grant;
  logic        wrDone;
  logic        rdDone;
  logic        incAddr;
  logic [1:0]  page;

  // ======================================================================
  // address latch and overlay
  // ======================================================================

  assign ldCtl = hostReg.latch && !hostReg.selN && !hostReg.data[15];
  assign ldOvl = hostReg.latch && !hostReg.selN && hostReg.data[15];

  assign pmSecond = !ctl.dmFlag && !pmFirst;
  // a write touches memory on a data word or on the second pm word.
  assign wrAccess = ctl.dmFlag || pmSecond;
  assign wrZero   = (wrCnt == 3'd0);
  assign rdZero   = (rdCnt == 3'd0);
  assign grant    = dsAck && (state == request);

  assign wrDone = !cycRead && ((state == waitCount && wrZero && !wrAccess) ||
                               (state == request && dsAck));
  assign rdDone = cycRead && ((state == waitCount && rdZero) ||
                              (state == readReturn));
  assign incAddr = (wrDone || rdDone) && (ctl.dmFlag || pmSecond);

  always_ff @(posedge DSPCLK or posedge RST) begin
    if (RST) begin
      ctl     <= '0;
      ovl     <= '0;
      pmFirst <= 1'b1;
    end else begin
      if (ldCtl) begin
        ctl <= idmaCtlT'(hostReg.data[14:0]);
      end else if (incAddr) begin
        ctl.addr <= ctl.addr + 14'd1;
      end
      if (ldOvl) begin
        ovl <= idmaOvlT'(hostReg.data[7:0]);
      end
      // any latch cycle restarts the pm word pair.
      if (ldCtl || ldOvl) begin
        pmFirst <= 1'b1;
      end else if ((wrDone || rdEnd) && !ctl.dmFlag) begin
        pmFirst <= !pmFirst;
      end
    end
  end

  // ======================================================================
  // host cycle FSM
  // ======================================================================

  always_ff @(posedge DSPCLK or posedge RST) begin
    if (RST) begin
      state    <= idle;
      cycRead  <= 1'b0;
      wrCnt    <= '0;
      rdCnt    <= '0;
      dsReq    <= 1'b0;
      hostAckN <= 1'b0;
    end else begin
      case (state)
        idle: begin
          if (wrBeg) begin
            cycRead  <= 1'b0;
            wrCnt    <= writeWait;
            hostAckN <= 1'b1;
            state    <= waitCount;
          end else if (rdBeg) begin
            cycRead  <= 1'b1;
            hostAckN <= 1'b1;
            // second pm read word is already held, only wait.
            if (pmSecond) begin
              rdCnt <= readWait;
              state <= waitCount;
            end else begin
              dsReq <= 1'b1;
              state <= request;
            end
          end
        end
        waitCount: begin
          if (cycRead) begin
            if (rdZero) begin
              hostAckN <= 1'b0;
              state    <= finish;
            end else begin
              rdCnt <= rdCnt - 3'd1;
            end
          end else if (!wrZero) begin
            wrCnt <= wrCnt - 3'd1;
          end else if (wrAccess) begin
            dsReq <= 1'b1;
            state <= request;
          end else begin
            hostAckN <= 1'b0;
            state    <= finish;
          end
        end
        request: begin
          if (dsAck) begin
            dsReq <= 1'b0;
            if (cycRead) begin
              state <= readReturn;
            end else begin
              hostAckN <= 1'b0;
              state    <= finish;
            end
          end
        end
        readReturn: begin
          hostAckN <= 1'b0;
          state    <= finish;
        end
        finish: begin
          // hold until the host drops its strobe.
          if (!rdCmd && !wrCmd) begin
            state <= idle;
          end
        end
        default: begin
          state <= idle;
        end
      endcase
    end
  end

  // holding registers, write side from the bus, read side from memory.
  always_ff @(posedge DSPCLK) begin
    if (state == waitCount && !cycRead && !hostReg.selN && !hostReg.wrN) begin
      if (pmSecond) begin
        dataLo <= hostReg.data[7:0];
      end else begin
        dataHi <= hostReg.data;
      end
    end else if (state == readReturn) begin
      if (ctl.dmFlag) begin
        dataHi <= dmRdata;
      end else begin
        dataHi <= pmRdata[23:8];
        dataLo <= pmRdata[7:0];
      end
    end
  end

  assign page = ctl.dmFlag ? ovl.dmPage[1:0] : ovl.pmPage[1:0];

  always_comb begin
    memReq.dmEn    = grant && ctl.dmFlag;
    memReq.pmEn    = grant && !ctl.dmFlag;
    memReq.writeEn = grant && !cycRead;
    memReq.address = {page, ctl.addr[addrBits-1:0]};
    memReq.wdata   = ctl.dmFlag ? {8'h00, dataHi} : {dataHi, dataLo};
  end

  assign hostData   = (ctl.dmFlag || pmFirst) ? dataHi : {8'h00, dataLo};
  assign hostDataOe = rdCmd || (cycRead && state != idle);

endmodule

// ==== rtl/stealArbiter.sv ====
`timescale 1ns/100ps

module stealArbiter #(
  parameter int stealLimit = 6
) (
  input  logic DSPCLK,
  input  logic RST,
  input  logic dsReq,
  input  logic coreBusy,
  output logic dsAck,
  output logic coreStall
);

  localparam int cntW = (stealLimit > 0) ? $clog2(stealLimit + 1) : 1;

  logic [cntW-1:0] waitCnt;
  logic            pending;
  logic            starved;
  logic            grant;

  // request still open, dsAck of this request not yet given.
  assign pending = dsReq && !dsAck;
  assign starved = (waitCnt == cntW'(stealLimit));

  // free slot, or the request has waited long enough.
  assign grant = pending && (!coreBusy || starved);

  always_ff @(posedge DSPCLK or posedge RST) begin
    if (RST) begin
      waitCnt   <= '0;
      dsAck     <= 1'b0;
      coreStall <= 1'b0;
    end else begin
      dsAck <= grant;
      // forced grant holds the core off for the stolen cycle.
      coreStall <= grant && coreBusy;
      if (!pending || grant) begin
        waitCnt <= '0;
      end else if (!starved) begin
        waitCnt <= waitCnt + 1'b1;
      end
    end
  end

endmodule

// ==== rtl/memoryBank.sv ====
`timescale 1ns/100ps

module memoryBank #(
  parameter int dataWidth = 16,
  parameter int depthBits = 12
) (
  input  logic                 DSPCLK,
  input  logic                 enable,
  input  logic                 writeEn,
  input  logic [depthBits-1:0] address,
  input  logic [dataWidth-1:0] wdata,
  output logic [dataWidth-1:0] rdata
);

  logic [dataWidth-1:0] mem [0:(1 << depthBits) - 1];

  // single port, read data one cycle after the enable.
  always_ff @(posedge DSPCLK) begin
    if (enable) begin
      if (writeEn) begin
        mem[address] <= wdata;
      end else begin
        rdata <= mem[address];
      end
    end
  end

endmodule

// ==== rtl/idmaTop.sv ====
`timescale 1ns/100ps

module idmaTop #(
  parameter int addrBits   = 10,
  parameter int stealLimit = 6
) (
  input  logic             DSPCLK,
  input  logic             RST,
  input  idmaPkg::hostBusT hostIn,
  input  logic [2:0]       writeWait,
  input  logic [2:0]       readWait,
  input  logic             coreBusy,
  output logic [15:0]      hostData,
  output logic             hostDataOe,
  output logic             hostAckN,
  output logic             coreStall
);

  import idmaPkg::*;

  hostBusT     hostReg;
  logic        rdCmd;
  logic        wrCmd;
  logic        rdBeg;
  logic        wrBeg;
  logic        rdEnd;
  logic        dsReq;
  logic        dsAck;
  memReqT      memReq;
  logic [15:0] dmRdata;
  logic [23:0] pmRdata;

  // ======================================================================
  // host side
  // ======================================================================

  hostSync sync0 (
    .DSPCLK  (DSPCLK),
    .RST     (RST),
    .hostIn  (hostIn),
    .hostReg (hostReg),
    .rdCmd   (rdCmd),
    .wrCmd   (wrCmd),
    .rdBeg   (rdBeg),
    .wrBeg   (wrBeg),
    .rdEnd   (rdEnd)
  );

  idmaPort #(
    .addrBits (addrBits)
  ) port0 (
    .DSPCLK     (DSPCLK),
    .RST        (RST),
    .hostReg    (hostReg),
    .rdCmd      (rdCmd),
    .wrCmd      (wrCmd),
    .rdBeg      (rdBeg),
    .wrBeg      (wrBeg),
    .rdEnd      (rdEnd),
    .writeWait  (writeWait),
    .readWait   (readWait),
    .dsAck      (dsAck),
    .dmRdata    (dmRdata),
    .pmRdata    (pmRdata),
    .dsReq      (dsReq),
    .memReq     (memReq),
    .hostData   (hostData),
    .hostDataOe (hostDataOe),
    .hostAckN   (hostAckN)
  );

  // ======================================================================
  // cycle steal and memories
  // ======================================================================

  stealArbiter #(
    .stealLimit (stealLimit)
  ) arb0 (
    .DSPCLK    (DSPCLK),
    .RST       (RST),
    .dsReq     (dsReq),
    .coreBusy  (coreBusy),
    .dsAck     (dsAck),
    .coreStall (coreStall)
  );

  memoryBank #(
    .dataWidth (16),
    .depthBits (memAddrW)
  ) dataMem (
    .DSPCLK  (DSPCLK),
    .enable  (memReq.dmEn),
    .writeEn (memReq.writeEn),
    .address (memReq.address),
    .wdata   (memReq.wdata[15:0]),
    .rdata   (dmRdata)
  );

  memoryBank #(
    .dataWidth (24),
    .depthBits (memAddrW)
  ) programMem (
    .DSPCLK  (DSPCLK),
    .enable  (memReq.pmEn),
    .writeEn (memReq.writeEn),
    .address (memReq.address),
    .wdata   (memReq.wdata),
    .rdata   (pmRdata)
  );

endmodule

// ==== verif/idmaTb.sv ====
`timescale 1ns/100ps

module idmaTb;

  import idmaPkg::*;

  localparam int addrBits = 10;

  logic        DSPCLK;
  logic        RST;
  hostBusT     hostIn;
  logic [2:0]  writeWait;
  logic [2:0]  readWait;
  logic        coreBusy;
  logic [15:0] hostData;
  logic        hostDataOe;
  logic        hostAckN;
  logic        coreStall;

  // reference memories keyed by {page, address}.
  logic [15:0] dmModel [int];
  logic [23:0] pmModel [int];
  logic [13:0] mAddr;
  logic        mDm;
  logic [1:0]  mDmPage;
  logic [1:0]  mPmPage;

  logic holdBusy;
  int   busyRun;
  int   hostCycles = 0;
  int   cycleCnt = 0;

  idmaTop #(
    .addrBits   (addrBits),
    .stealLimit (6)
  ) dut0 (
    .DSPCLK     (DSPCLK),
    .RST        (RST),
    .hostIn     (hostIn),
    .writeWait  (writeWait),
    .readWait   (readWait),
    .coreBusy   (coreBusy),
    .hostData   (hostData),
    .hostDataOe (hostDataOe),
    .hostAckN   (hostAckN),
    .coreStall  (coreStall)
  );

  initial begin
    DSPCLK = 1'b0;
    forever #2 DSPCLK = ~DSPCLK;
  end

  // each host cycle may take up to 200 clocks.
  always @(posedge DSPCLK) begin
    cycleCnt = cycleCnt + 1;
    if (cycleCnt > 200 * hostCycles + 1000) begin
      $display("Timeout at %0t: the DUT stopped answering after %0d cycles", $time, cycleCnt);
      $display("FAIL: see errors above");
      $fatal(1);
    end
  end

  // ======================================================================
  // checks and clocking
  // ======================================================================

  task automatic checkEq(input string name, input logic [15:0] got, input logic [15:0] exp);
    assert (got === exp) else begin
      $display("** Error at %0t: %s = 0x%h, expected 0x%h", $time, name, got, exp);
      $display("FAIL: see errors above");
      $fatal(1);
    end
  endtask

  task automatic checkTrue(input logic cond, input string msg);
    assert (cond === 1'b1) else begin
      $display("Failure at %0t: %s", $time, msg);
      $display("FAIL: see errors above");
      $fatal(1);
    end
  endtask

  // one clock, then new core load; busy about 60% with some long runs.
  task automatic tick();
    int r;
    @(posedge DSPCLK);
    #1;
    if (holdBusy) begin
      coreBusy = 1'b1;
    end else if (busyRun > 0) begin
      coreBusy = 1'b1;
      busyRun--;
    end else begin
      r = $urandom_range(99, 0);
      if (r < 3) begin
        busyRun = 15 + $urandom_range(15, 0);
      end
      coreBusy = (r < 60);
    end
  endtask

  // ======================================================================
  // host cycles
  // ======================================================================

  task automatic waitAck(output int stalls);
    int n;
    stalls = 0;
    n = 0;
    do begin
      tick();
      stalls += coreStall;
      n++;
    end while (!hostAckN && n < 8);
    checkTrue(hostAckN, "acknowledge did not go busy after the strobe");
    while (hostAckN) begin
      tick();
      stalls += coreStall;
    end
  endtask

  task automatic latchCycle(input logic [15:0] word);
    hostCycles++;
    hostIn.selN  = 1'b0;
    hostIn.latch = 1'b1;
    hostIn.data  = word;
    tick();
    tick();
    hostIn.selN  = 1'b1;
    hostIn.latch = 1'b0;
    tick();
    tick();
  endtask

  task automatic hostWrite(input logic [15:0] word);
    int stalls;
    hostCycles++;
    hostIn.selN = 1'b0;
    hostIn.wrN  = 1'b0;
    hostIn.data = word;
    waitAck(stalls);
    checkTrue(stalls <= 1, "coreStall pulsed more than once in one write");
    hostIn.selN = 1'b1;
    hostIn.wrN  = 1'b1;
    tick();
    tick();
  endtask

  task automatic hostRead(output logic [15:0] word);
    int stalls;
    hostCycles++;
    hostIn.selN = 1'b0;
    hostIn.rdN  = 1'b0;
    waitAck(stalls);
    checkTrue(stalls <= 1, "coreStall pulsed more than once in one read");
    checkTrue(hostDataOe, "hostDataOe low while read data is returned");
    word = hostData;
    hostIn.selN = 1'b1;
    hostIn.rdN  = 1'b1;
    tick();
    tick();
  endtask

  // ======================================================================
  // model side
  // ======================================================================

  function automatic int modelKey();
    logic [1:0] page;
    page = mDm ? mDmPage : mPmPage;
    return int'({page, mAddr[addrBits-1:0]});
  endfunction

  task automatic setCtl(input logic dm, input logic [13:0] addr);
    latchCycle({1'b0, dm, addr});
    mDm   = dm;
    mAddr = addr;
  endtask

  task automatic setOvl(input logic [1:0] dmP, input logic [1:0] pmP);
    latchCycle({8'h80, 2'b00, pmP, 2'b00, dmP});
    mDmPage = dmP;
    mPmPage = pmP;
  endtask

  task automatic dmWrite(input logic [15:0] v);
    hostWrite(v);
    dmModel[modelKey()] = v;
    mAddr++;
  endtask

  task automatic dmRead();
    int          key;
    logic [15:0] got;
    key = modelKey();
    hostRead(got);
    if (dmModel.exists(key)) begin
      checkEq("hostData", got, dmModel[key]);
    end
    mAddr++;
  endtask

  // upper byte of the second word is don't care on a write.
  task automatic pmWrite(input logic [23:0] v);
    logic [7:0] junk;
    junk = 8'($urandom);
    hostWrite(v[23:8]);
    hostWrite({junk, v[7:0]});
    pmModel[modelKey()] = v;
    mAddr++;
  endtask

  task automatic pmRead();
    int          key;
    logic [15:0] hi;
    logic [15:0] lo;
    key = modelKey();
    hostRead(hi);
    hostRead(lo);
    if (pmModel.exists(key)) begin
      checkEq("hostData (pm high word)", hi, pmModel[key][23:8]);
      checkEq("hostData (pm low byte)", lo, {8'h00, pmModel[key][7:0]});
    end
    mAddr++;
  endtask

  task automatic randomWaits();
    writeWait = 3'($urandom);
    readWait  = 3'($urandom);
  endtask

  // ======================================================================
  // test sequence
  // ======================================================================

  initial begin
    int          len;
    int          op;
    logic [13:0] base;
    void'($urandom(28528));
    RST       = 1'b1;
    hostIn    = '{selN: 1'b1, latch: 1'b0, rdN: 1'b1, wrN: 1'b1, data: 16'h0000};
    writeWait = 3'd0;
    readWait  = 3'd0;
    coreBusy  = 1'b0;
    holdBusy  = 1'b0;
    busyRun   = 0;
    mAddr     = '0;
    mDm       = 1'b0;
    mDmPage   = '0;
    mPmPage   = '0;
    repeat (10) tick();
    RST = 1'b0;
    tick();
    tick();
    checkEq("hostAckN", 16'(hostAckN), 16'h0000);
    checkEq("hostDataOe", 16'(hostDataOe), 16'h0000);
    checkEq("coreStall", 16'(coreStall), 16'h0000);

    // data memory bursts with auto increment.
    setOvl(2'($urandom), 2'($urandom));
    for (int b = 0; b < 4; b++) begin
      randomWaits();
      len  = $urandom_range(10, 3);
      base = 14'($urandom_range(1023, 0));
      setCtl(1'b1, base);
      repeat (len) dmWrite(16'($urandom));
      setCtl(1'b1, base);
      repeat (len) dmRead();
    end

    // program memory word pairs.
    for (int b = 0; b < 3; b++) begin
      randomWaits();
      len  = $urandom_range(6, 2);
      base = 14'($urandom_range(1023, 0));
      setCtl(1'b0, base);
      repeat (len) pmWrite(24'($urandom));
      setCtl(1'b0, base);
      repeat (len) pmRead();
    end

    // one address under every page.
    base = 14'($urandom_range(1023, 0));
    for (int p = 0; p < 4; p++) begin
      setOvl(2'(p), 2'(3 - p));
      setCtl(1'b1, base);
      dmWrite(16'($urandom));
      setCtl(1'b0, base);
      pmWrite(24'($urandom));
    end
    for (int p = 0; p < 4; p++) begin
      setOvl(2'(p), 2'(3 - p));
      setCtl(1'b1, base);
      dmRead();
      setCtl(1'b0, base);
      pmRead();
    end

    // core busy throughout, every grant is a forced steal.
    holdBusy = 1'b1;
    for (int b = 0; b < 3; b++) begin
      randomWaits();
      base = 14'($urandom_range(1023, 0));
      setCtl(1'b1, base);
      repeat (2) dmWrite(16'($urandom));
      setCtl(1'b1, base);
      repeat (2) dmRead();
      setCtl(1'b0, base);
      pmWrite(24'($urandom));
      setCtl(1'b0, base);
      pmRead();
    end
    holdBusy = 1'b0;

    // small window so reads often hit written words.
    repeat (80) begin
      op = $urandom_range(5, 0);
      case (op)
        0: setCtl(1'($urandom), 14'($urandom_range(31, 0)));
        1: setOvl(2'($urandom), 2'($urandom));
        2: randomWaits();
        3, 4: begin
          if (mDm) begin
            dmWrite(16'($urandom));
          end else begin
            pmWrite(24'($urandom));
          end
        end
        default: begin
          if (mDm) begin
            dmRead();
          end else begin
            pmRead();
          end
        end
      endcase
    end

    $display("PASS: all tests");
    $finish;
  end

endmodule

// ==== sources.f ====
rtl/idmaPkg.sv
rtl/hostSync.sv
rtl/idmaPort.sv
rtl/stealArbiter.sv
rtl/memoryBank.sv
rtl/idmaTop.sv
verif/idmaTb.sv

// ==== Bender.yml ====
package:
  name: idma

sources:
  - files:
      - rtl/idmaPkg.sv
      - rtl/hostSync.sv
      - rtl/idmaPort.sv
      - rtl/stealArbiter.sv
      - rtl/memoryBank.sv
      - rtl/idmaTop.sv
  - target: simulation
    files:
      - verif/idmaTb.sv
